//--- hw/fir_ctrl_regs.sv
`include "fir_defines.svh"

module fir_ctrl_regs (
  input  logic               axis_clk,
  input  logic               axis_rst_n,
  input  logic               awvalid,
  input  logic               wvalid,
  input  logic               arvalid,
  input  logic               rready,
  input  fir_pkg::addr_t     awaddr,
  input  fir_pkg::addr_t     araddr,
  input  fir_pkg::data_t     wdata,
  output logic               awready,
  output logic               wready,
  output logic               arready,
  output logic               rvalid,
  output fir_pkg::data_t     rdata,
  output fir_pkg::fir_cfg_t  cfg,
  output logic               ap_start,
  input  logic               frame_done,
  input  fir_pkg::bram_req_t eng_tap_req,
  output fir_pkg::bram_req_t tap_req,
  input  fir_pkg::data_t     tap_do
);
  import fir_pkg::*;

  lite_state_e state_q;
  lite_state_e state_d;
  addr_t       addr_q;     // address of the transaction in progress
  data_t       rdata_q;
  data_t       reg_rdata;
  logic        rvalid_q;
  logic        rd_tap_q;   // tap RAM was really read
  logic        ap_idle;
  logic        ap_done;
  logic        is_tap;
  logic        rd_done;
  fir_cfg_t    cfg_q;
  bram_req_t   lite_req;

  assign is_tap  = (addr_q & ~`FIR_ADDR_MASK) == `FIR_TAP_BASE;
  assign rd_done = (state_q == LITE_READ_DATA) && rvalid_q && rready;

  assign awready = (state_q == LITE_WRITE);
  assign wready  = (state_q == LITE_WRITE);
  assign arready = (state_q == LITE_READ_ADDR);
  assign rvalid  = rvalid_q;
  assign rdata   = rdata_q;
  assign cfg     = cfg_q;

  // one transaction at a time and writes win
  always_comb begin
    state_d = state_q;
    case (state_q)
      LITE_IDLE: begin
        if (awvalid && wvalid) begin
          state_d = LITE_WRITE;
        end else if (arvalid) begin
          state_d = LITE_READ_ADDR;
        end
      end
      LITE_WRITE:     state_d = LITE_IDLE;
      LITE_READ_ADDR: state_d = LITE_READ_DATA;
      LITE_READ_DATA: if (rd_done) state_d = LITE_IDLE;
      default:        state_d = LITE_IDLE;
    endcase
  end

  always_comb begin
    case (addr_q)
      `FIR_REG_AP_CTRL:  reg_rdata = data_t'({ap_idle, ap_done, ap_start});
      `FIR_REG_DATA_LEN: reg_rdata = cfg_q.data_length;
      `FIR_REG_TAP_LEN:  reg_rdata = data_t'(cfg_q.tap_length);
      default:           reg_rdata = '0;  // unmapped
    endcase
  end

  // coefficient access while idle
  always_comb begin
    lite_req      = '0;
    lite_req.en   = is_tap && ((state_q == LITE_WRITE) || (state_q == LITE_READ_ADDR));
    lite_req.we   = (is_tap && (state_q == LITE_WRITE)) ? 4'hF : 4'h0;
    lite_req.addr = addr_q & `FIR_ADDR_MASK;
    lite_req.data = wdata;
  end

  assign tap_req = ap_idle ? lite_req : eng_tap_req;  // engine owns the port when busy

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q  <= LITE_IDLE;
      rvalid_q <= 1'b0;
      rd_tap_q <= 1'b0;
      cfg_q    <= '0;
      ap_start <= 1'b0;
      ap_idle  <= 1'b1;
      ap_done  <= 1'b0;
    end else begin
      state_q <= state_d;

      if ((state_q == LITE_READ_ADDR && !is_tap) || (state_q == LITE_READ_DATA && !rvalid_q)) begin
        rvalid_q <= 1'b1;
      end else if (rd_done) begin
        rvalid_q <= 1'b0;
      end
      if (state_q == LITE_READ_ADDR) rd_tap_q <= ap_idle;

      // lengths are locked while a frame runs
      if (state_q == LITE_WRITE && ap_idle) begin
        if (addr_q == `FIR_REG_DATA_LEN) cfg_q.data_length <= wdata;
        if (addr_q == `FIR_REG_TAP_LEN)  cfg_q.tap_length  <= tap_cnt_t'(wdata);
      end

      ap_start <= (state_q == LITE_WRITE) && ap_idle && (addr_q == `FIR_REG_AP_CTRL) && wdata[0];

      if (ap_start) begin
        ap_idle <= 1'b0;
      end else if (frame_done) begin
        ap_idle <= 1'b1;
      end

      if (frame_done) begin
        ap_done <= 1'b1;
      end else if (rd_done && addr_q == `FIR_REG_AP_CTRL) begin
        ap_done <= 1'b0;  // cleared by reading status
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (state_q == LITE_IDLE) begin
      if (awvalid && wvalid) begin
        addr_q <= awaddr;
      end else if (arvalid) begin
        addr_q <= araddr;
      end
    end
    if (state_q == LITE_READ_ADDR && !is_tap) begin
      rdata_q <= reg_rdata;
    end else if (state_q == LITE_READ_DATA && !rvalid_q) begin
      rdata_q <= rd_tap_q ? tap_do : `FIR_BAD_READ;
    end
  end

endmodule

//--- hw/fir_defines.svh
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// bus widths
`define FIR_ADDR_W 12
`define FIR_DATA_W 32

// 128-byte tap window holds 32 words
`define FIR_MAX_TAPS 32

// register map
`define FIR_REG_AP_CTRL  12'h000
`define FIR_REG_DATA_LEN 12'h010
`define FIR_REG_TAP_LEN  12'h014
`define FIR_TAP_BASE     12'h080
`define FIR_ADDR_MASK    12'h07F

// returned for a tap read while busy
`define FIR_BAD_READ {`FIR_DATA_W{1'b1}}

`endif

//--- hw/fir_engine.sv
module fir_engine (
  input  logic               axis_clk,
  input  logic               axis_rst_n,
  input  logic               ap_start,
  input  fir_pkg::fir_cfg_t  cfg,
  input  logic               ss_tvalid,
  input  fir_pkg::data_t     ss_tdata,
  output logic               ss_tready,
  input  logic               out_busy,
  output fir_pkg::bram_req_t tap_req,
  output fir_pkg::bram_req_t data_req,
  output fir_pkg::mac_ctl_t  mac_ctl
);
  import fir_pkg::*;

  eng_state_e  state_q;
  eng_state_e  state_d;
  sample_cnt_t taken_q;    // samples accepted in this frame
  tap_cnt_t    fill_q;     // valid ring entries
  tap_cnt_t    wr_slot_q;  // ring slot of the current sample
  tap_cnt_t    rd_slot_q;
  tap_cnt_t    tap_idx_q;
  tap_cnt_t    last_slot;
  data_t       x_q;
  logic        take;
  logic        sum_last;
  logic        frame_end;

  // word index to RAM byte address
  function automatic addr_t word_addr(tap_cnt_t idx);
    return addr_t'({idx, 2'b00});
  endfunction

  assign last_slot = cfg.tap_length - 1'b1;
  assign take      = (state_q == ENG_WAIT_IN) && ss_tvalid && !out_busy;
  assign ss_tready = take;
  assign sum_last  = (state_q == ENG_SUM) && (tap_idx_q == fill_q - 1'b1);
  assign frame_end = (taken_q == cfg.data_length);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE:    if (ap_start) state_d = ENG_WAIT_IN;
      ENG_WAIT_IN: if (take) state_d = ENG_WRITE_X;
      ENG_WRITE_X: state_d = ENG_SUM;
      ENG_SUM: begin
        if (sum_last) begin
          state_d = frame_end ? ENG_IDLE : ENG_WAIT_IN;
        end
      end
      default:     state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state_q   <= ENG_IDLE;
      taken_q   <= '0;
      fill_q    <= '0;
      wr_slot_q <= '0;
      rd_slot_q <= '0;
      tap_idx_q <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        ENG_IDLE: begin
          if (ap_start) begin  // ring restarts for each frame
            taken_q   <= '0;
            fill_q    <= '0;
            wr_slot_q <= '0;
          end
        end
        ENG_WAIT_IN: begin
          if (take) begin
            taken_q <= taken_q + 1'b1;
            if (fill_q != cfg.tap_length) fill_q <= fill_q + 1'b1;
          end
        end
        ENG_WRITE_X: begin
          rd_slot_q <= wr_slot_q;   // newest sample first
          tap_idx_q <= '0;
          wr_slot_q <= (wr_slot_q == last_slot) ? '0 : wr_slot_q + 1'b1;
        end
        ENG_SUM: begin
          rd_slot_q <= (rd_slot_q == '0) ? last_slot : rd_slot_q - 1'b1;
          tap_idx_q <= tap_idx_q + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge axis_clk) begin
    if (take) x_q <= ss_tdata;
  end

  always_comb begin
    data_req = '0;
    tap_req  = '0;
    mac_ctl  = '0;
    case (state_q)
      ENG_WRITE_X: begin
        data_req.en   = 1'b1;
        data_req.we   = 4'hF;
        data_req.addr = word_addr(wr_slot_q);
        data_req.data = x_q;
      end
      ENG_SUM: begin
        // x[n-k] and h[k]
        data_req.en        = 1'b1;
        data_req.addr      = word_addr(rd_slot_q);
        tap_req.en         = 1'b1;
        tap_req.addr       = word_addr(tap_idx_q);
        mac_ctl.valid      = 1'b1;
        mac_ctl.first      = (tap_idx_q == '0);
        mac_ctl.last       = sum_last;
        mac_ctl.frame_last = sum_last && frame_end;
      end
      default: ;
    endcase
  end

endmodule

//--- hw/fir_mac.sv
module fir_mac (
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  fir_pkg::mac_ctl_t mac_ctl,
  input  fir_pkg::data_t    tap_do,
  input  fir_pkg::data_t    data_do,
  input  logic              sm_tready,
  output logic              sm_tvalid,
  output logic              sm_tlast,
  output fir_pkg::data_t    sm_tdata,
  output logic              out_busy,
  output logic              frame_done
);
  import fir_pkg::*;

  mac_ctl_t ctl_q;  // lines up with the RAM read data
  data_t    acc_q;
  data_t    sum;
  data_t    out_data_q;
  logic     out_valid_q;
  logic     out_last_q;
  logic     out_take;

  // wraps modulo 2^32
  assign sum = (ctl_q.first ? '0 : acc_q) + data_t'(tap_do * data_do);

  assign out_take   = out_valid_q && sm_tready;
  assign sm_tvalid  = out_valid_q;
  assign sm_tlast   = out_last_q;
  assign sm_tdata   = out_data_q;
  assign frame_done = out_take && out_last_q;
  assign out_busy   = out_valid_q || ctl_q.valid;  // result held or still on its way

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ctl_q       <= '0;
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      ctl_q <= mac_ctl;
      if (ctl_q.valid && ctl_q.last) begin
        out_valid_q <= 1'b1;
        out_last_q  <= ctl_q.frame_last;
      end else if (out_take) begin
        out_valid_q <= 1'b0;
        out_last_q  <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (ctl_q.valid) acc_q <= sum;
    if (ctl_q.valid && ctl_q.last) out_data_q <= sum;  // held until taken
  end

endmodule

//--- hw/fir_pkg.sv
`include "fir_defines.svh"

package fir_pkg;

  typedef logic [`FIR_ADDR_W-1:0] addr_t;
  typedef logic [`FIR_DATA_W-1:0] data_t;
  typedef logic [$clog2(`FIR_MAX_TAPS):0] tap_cnt_t;  // 0 .. max taps
  typedef logic [`FIR_DATA_W-1:0] sample_cnt_t;

  // one request to a single-port block RAM
  typedef struct packed {
    logic       en;
    logic [3:0] we;
    addr_t      addr;
    data_t      data;
  } bram_req_t;

  typedef struct packed {
    sample_cnt_t data_length;
    tap_cnt_t    tap_length;
  } fir_cfg_t;

  typedef struct packed {
    logic valid;       // RAM reads of this cycle form a product
    logic first;       // restart the accumulator
    logic last;        // product completes an output
    logic frame_last;  // final output of the frame
  } mac_ctl_t;

  typedef enum logic [1:0] {LITE_IDLE, LITE_WRITE, LITE_READ_ADDR, LITE_READ_DATA} lite_state_e;
  typedef enum logic [1:0] {ENG_IDLE, ENG_WAIT_IN, ENG_WRITE_X, ENG_SUM} eng_state_e;

endpackage

//--- hw/fir_top.sv
module fir_top (
  output logic           awready,
  output logic           wready,
  input  logic           awvalid,
  input  fir_pkg::addr_t awaddr,
  input  logic           wvalid,
  input  fir_pkg::data_t wdata,
  output logic           arready,
  input  logic           rready,
  input  logic           arvalid,
  input  fir_pkg::addr_t araddr,
  output logic           rvalid,
  output fir_pkg::data_t rdata,
  input  logic           ss_tvalid,
  input  fir_pkg::data_t ss_tdata,
  output logic           ss_tready,
  input  logic           sm_tready,
  output logic           sm_tvalid,
  output fir_pkg::data_t sm_tdata,
  output logic           sm_tlast,
  // coefficient RAM
  output logic [3:0]     tap_we,
  output logic           tap_en,
  output fir_pkg::data_t tap_di,
  output fir_pkg::addr_t tap_a,
  input  fir_pkg::data_t tap_do,
  // sample history RAM
  output logic [3:0]     data_we,
  output logic           data_en,
  output fir_pkg::data_t data_di,
  output fir_pkg::addr_t data_a,
  input  fir_pkg::data_t data_do,
  input  logic           axis_clk,
  input  logic           axis_rst_n
);
  import fir_pkg::*;

  fir_cfg_t  cfg;
  logic      ap_start;
  logic      frame_done;
  logic      out_busy;
  bram_req_t eng_tap_req;
  bram_req_t tap_req;
  bram_req_t data_req;
  mac_ctl_t  mac_ctl;

  assign tap_en  = tap_req.en;
  assign tap_we  = tap_req.we;
  assign tap_a   = tap_req.addr;
  assign tap_di  = tap_req.data;
  assign data_en = data_req.en;
  assign data_we = data_req.we;
  assign data_a  = data_req.addr;
  assign data_di = data_req.data;

  fir_ctrl_regs u_ctrl_regs (
    .axis_clk, .axis_rst_n,
    .awvalid, .wvalid, .arvalid, .rready,
    .awaddr, .araddr, .wdata,
    .awready, .wready, .arready, .rvalid, .rdata,
    .cfg, .ap_start, .frame_done,
    .eng_tap_req, .tap_req, .tap_do
  );

  fir_engine u_engine (
    .axis_clk, .axis_rst_n,
    .ap_start, .cfg,
    .ss_tvalid, .ss_tdata, .ss_tready,
    .out_busy,
    .tap_req(eng_tap_req), .data_req, .mac_ctl
  );

  fir_mac u_mac (
    .axis_clk, .axis_rst_n,
    .mac_ctl, .tap_do, .data_do,
    .sm_tready, .sm_tvalid, .sm_tlast, .sm_tdata,
    .out_busy, .frame_done
  );

endmodule

//--- list.f
+incdir+hw
hw/fir_pkg.sv
hw/fir_ctrl_regs.sv
hw/fir_engine.sv
hw/fir_mac.sv
hw/fir_top.sv
tb/fir_bram_model.sv
tb/tb_fir.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_fir \
  --Mdir obj_dir -o sim_tb_fir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_fir > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

//--- tb/fir_bram_model.sv
`include "fir_defines.svh"

module fir_bram_model (
  input  logic           axis_clk,
  input  logic           en,
  input  logic [3:0]     we,
  input  fir_pkg::addr_t addr,
  input  fir_pkg::data_t di,
  output fir_pkg::data_t dout
);
  import fir_pkg::*;

  localparam int WORDS = 1 << (`FIR_ADDR_W - 2);

  data_t                  mem [WORDS];
  logic [`FIR_ADDR_W-3:0] word;  // byte address to word index

  assign word = addr[`FIR_ADDR_W-1:2];

  // one cycle read latency and old data on a write
  always_ff @(posedge axis_clk) begin
    if (en) begin
      for (int b = 0; b < 4; b++) begin
        if (we[b]) mem[word][8*b +: 8] <= di[8*b +: 8];
      end
      dout <= mem[word];
    end
  end

endmodule

//--- tb/tb_fir.sv
`include "fir_defines.svh"

module tb_fir;
  import fir_pkg::*;

  localparam int TIMEOUT = 1000;  // cycles per wait

  logic axis_clk, axis_rst_n;
  logic awready, wready, awvalid, wvalid, arready, arvalid, rready, rvalid;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  logic ss_tvalid, ss_tready, sm_tready, sm_tvalid, sm_tlast;
  data_t ss_tdata, sm_tdata;
  logic [3:0] tap_we, data_we;
  logic tap_en, data_en;
  data_t tap_di, tap_do, data_di, data_do;
  addr_t tap_a, data_a;

  int seed = 10;
  int n_checks = 0;
  int n_errors = 0;
  data_t h_mem [`FIR_MAX_TAPS];
  data_t x_mem [256];
  data_t y_exp [256];

  fir_top u_dut (.*);

  fir_bram_model u_tap_ram (
    .axis_clk, .en(tap_en), .we(tap_we), .addr(tap_a), .di(tap_di), .dout(tap_do)
  );

  fir_bram_model u_data_ram (
    .axis_clk, .en(data_en), .we(data_we), .addr(data_a), .di(data_di), .dout(data_do)
  );

  initial begin
    axis_clk = 1'b0;
    forever #4 axis_clk = ~axis_clk;
  end

  task automatic check_value(input string name, input data_t got, input data_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input logic seen, input string what);
    assert (seen) else begin
      n_errors++;
      $display("ERROR at %0t: timed out waiting for %s", $time, what);
    end
  endtask

  function automatic addr_t tap_addr(input int k);
    return `FIR_TAP_BASE + addr_t'(4 * k);
  endfunction

  // aw and w together and held until the ready pulse
  task automatic axi_write(input addr_t addr, input data_t data);
    logic seen;
    @(negedge axis_clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    seen    = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
      @(posedge axis_clk);
      seen = awready && wready;
    end
    report_timeout(seen, "awready/wready");
    @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, output data_t data);
    logic seen;
    @(negedge axis_clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    seen    = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
      @(posedge axis_clk);
      seen = arready;
    end
    report_timeout(seen, "arready");
    @(negedge axis_clk);
    arvalid = 1'b0;
    seen    = 1'b0;
    for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
      @(posedge axis_clk);
      seen = rvalid;
    end
    report_timeout(seen, "rvalid");
    data = rdata;
    @(negedge axis_clk);
    rready = 1'b0;
  endtask

  task automatic fill_samples(input int len);
    for (int i = 0; i < len; i++) begin
      x_mem[i] = $random(seed) % 16;  // small signed values
    end
  endtask

  // y[n] = sum of h[k] * x[n-k] over the samples seen so far
  task automatic compute_reference(input int len, input int taps);
    int    p;
    data_t acc;
    for (int n = 0; n < len; n++) begin
      p   = (n + 1 < taps) ? n + 1 : taps;
      acc = '0;
      for (int k = 0; k < p; k++) begin
        acc = acc + h_mem[k] * x_mem[n-k];
      end
      y_exp[n] = acc;
    end
  endtask

  task automatic send_frame(input int len);
    logic seen;
    for (int i = 0; i < len; i++) begin
      @(negedge axis_clk);
      ss_tvalid = 1'b1;
      ss_tdata  = x_mem[i];
      seen      = 1'b0;
      for (int cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
        @(posedge axis_clk);
        seen = ss_tready;
      end
      report_timeout(seen, "ss_tready");
      if (!seen) break;
    end
    @(negedge axis_clk);
    ss_tvalid = 1'b0;
  endtask

  task automatic check_frame(input int len, input logic stall);
    int    idx;
    int    idle;
    logic  holding;
    logic  extra;
    data_t held;
    idx     = 0;
    idle    = 0;
    holding = 1'b0;
    extra   = 1'b0;
    while (idx < len && idle < TIMEOUT) begin
      @(negedge axis_clk);
      sm_tready = stall ? (($random(seed) & 3) != 0) : 1'b1;
      @(posedge axis_clk);
      idle++;
      if (sm_tvalid) begin
        if (holding) check_value("sm_tdata while stalled", sm_tdata, held);
        if (sm_tready) begin
          check_value("sm_tdata", sm_tdata, y_exp[idx]);
          check_value("sm_tlast", 32'(sm_tlast), 32'(idx == len - 1));
          idx++;
          idle    = 0;
          holding = 1'b0;
        end else begin
          held    = sm_tdata;
          holding = 1'b1;
        end
      end
    end
    report_timeout(idx == len, "all outputs of the frame");
    @(negedge axis_clk);
    sm_tready = 1'b1;
    for (int cyc = 0; cyc < 20; cyc++) begin
      @(posedge axis_clk);
      if (sm_tvalid) extra = 1'b1;
    end
    assert (!extra) else begin
      n_errors++;
      $display("ERROR at %0t: output appeared after the frame had ended", $time);
    end
  endtask

  task automatic test_registers();
    data_t rd;
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_ctrl after reset", rd, 32'd4);
    axi_write(`FIR_REG_DATA_LEN, 32'd64);
    axi_write(`FIR_REG_TAP_LEN, 32'd11);
    axi_read(`FIR_REG_DATA_LEN, rd);
    check_value("data_length", rd, 32'd64);
    axi_read(`FIR_REG_TAP_LEN, rd);
    check_value("tap_length", rd, 32'd11);
    for (int k = 0; k < 11; k++) begin
      h_mem[k] = $random(seed) % 16;
      axi_write(tap_addr(k), h_mem[k]);
    end
    for (int k = 0; k < 11; k++) begin
      axi_read(tap_addr(k), rd);
      check_value("tap coefficient", rd, h_mem[k]);
    end
    axi_read(12'h020, rd);
    check_value("unmapped register", rd, 32'd0);
  endtask

  // full frame with status and busy locking
  task automatic test_full_frame();
    data_t rd;
    fill_samples(64);
    compute_reference(64, 11);
    axi_write(`FIR_REG_AP_CTRL, 32'd1);
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_idle while busy", 32'(rd[2]), 32'd0);
    axi_write(`FIR_REG_TAP_LEN, 32'd5);
    axi_write(tap_addr(0), 32'h55);
    axi_read(`FIR_REG_TAP_LEN, rd);
    check_value("tap_length while busy", rd, 32'd11);
    axi_read(tap_addr(1), rd);
    check_value("tap read while busy", rd, `FIR_BAD_READ);
    fork
      send_frame(64);
      check_frame(64, 1'b0);
    join
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_ctrl after frame", rd, 32'd6);
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_ctrl after done cleared", rd, 32'd4);
    axi_read(tap_addr(0), rd);
    check_value("coefficient after busy write", rd, h_mem[0]);
  endtask

  task automatic test_back_pressure();
    data_t rd;
    fill_samples(64);
    compute_reference(64, 11);
    axi_write(`FIR_REG_AP_CTRL, 32'd1);
    fork
      send_frame(64);
      check_frame(64, 1'b1);
    join
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_ctrl after stalled frame", rd, 32'd6);
  endtask

  task automatic test_second_frame();
    data_t rd;
    axi_write(`FIR_REG_TAP_LEN, 32'd3);
    axi_write(`FIR_REG_DATA_LEN, 32'd20);
    fill_samples(20);
    compute_reference(20, 3);
    axi_write(`FIR_REG_AP_CTRL, 32'd1);
    fork
      send_frame(20);
      check_frame(20, 1'b0);
    join
    axi_read(`FIR_REG_AP_CTRL, rd);
    check_value("ap_ctrl after short frame", rd, 32'd6);
  endtask

  initial begin
    axis_rst_n = 1'b0;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    ss_tvalid  = 1'b0;
    ss_tdata   = '0;
    sm_tready  = 1'b0;
    repeat (8) @(posedge axis_clk);
    @(negedge axis_clk);
    axis_rst_n = 1'b1;

    test_registers();
    test_full_frame();
    test_back_pressure();
    test_second_frame();

    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
